//--- Makefile
# Verilator build and run for the host-link harness

VERILATOR ?= verilator
TOP       ?= coreTestHarnessTb
FILELIST  ?= hostLink.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- hostLink.f
+incdir+include
src/hostLinkPkg.sv
src/channelSplit.sv
src/channelMerge.sv
src/deserializer.sv
src/core.sv
src/coreTestHarness.sv
test/coreTestHarnessTb.sv

//--- include/hostLink_config.svh
`ifndef HOSTLINK_CONFIG_SVH
`define HOSTLINK_CONFIG_SVH

// host word layout, code on top of payload
`define HOST_CODE_W 8
`define HOST_DATA_W 24

// register command fields inside the payload
`define REG_ADDR_W 8
`define REG_DATA_W 16

// bias-driver word widths
`define BD_IN_W 34
`define BD_OUT_W 21

// stream codes
`define CODE_TO_BD 8'hFF
`define CODE_FROM_BD 8'hFF
`define CODE_WRITE 8'h00
`define CODE_READ 8'h01

// register file size, 16-bit registers
`define NUM_REGS 16

// writes in 80..9F go out to the bias driver
`define BD_ADDR_BASE 8'h80

`endif

//--- src/channelMerge.sv
`timescale 1ns/100ps
`default_nettype none

`include "hostLink_config.svh"

// two streams onto one, round robin, one output register
module channelMerge (
  input  logic                 clk,
  input  logic                 reset,
  input  hostLinkPkg::hostWord a,
  input  logic                 aValid,
  output logic                 aReady,
  input  hostLinkPkg::hostWord b,
  input  logic                 bValid,
  output logic                 bReady,
  output hostLinkPkg::hostWord out,
  output logic                 outValid,
  input  logic                 outReady
);

  // set when a wins the next tie
  logic preferA;
  logic canLoad;
  logic grantA;
  logic grantB;

  // output slot is free or is being drained this cycle
  assign canLoad = ~outValid | outReady;

  // on a tie the flag decides, otherwise whoever is valid
  assign grantA = aValid & (~bValid | preferA);
  assign grantB = bValid & (~aValid | ~preferA);

  assign aReady = canLoad & grantA;
  assign bReady = canLoad & grantB;

  ////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
      // core replies come first after reset
      preferA <= 1'b1;
    end else begin
      if (canLoad) begin
        outValid <= aValid | bValid;
      end
      // flip priority away from whoever just got through
      if (aReady) begin
        preferA <= 1'b0;
      end else if (bReady) begin
        preferA <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output word

  always_ff @(posedge clk) begin
    if (aReady) begin
      out <= a;
    end else if (bReady) begin
      out <= b;
    end
  end

endmodule

`default_nettype wire

//--- src/channelSplit.sv
`timescale 1ns/100ps
`default_nettype none

`include "hostLink_config.svh"

// steer each host word to a or b by its code
// no state here, a word passes in the same cycle
module channelSplit #(
  parameter logic [`HOST_CODE_W-1:0] codeMatch = `CODE_TO_BD,
  parameter logic [`HOST_CODE_W-1:0] codeMask = {`HOST_CODE_W{1'b1}}
) (
  input  hostLinkPkg::hostWord in,
  input  logic                 inValid,
  output logic                 inReady,
  output hostLinkPkg::hostWord a,
  output logic                 aValid,
  input  logic                 aReady,
  output hostLinkPkg::hostWord b,
  output logic                 bValid,
  input  logic                 bReady
);

  logic toA;

  // masked compare, bits outside the mask never matter
  assign toA = (in.code & codeMask) == (codeMatch & codeMask);

  // data fans out to both sides, only one valid is raised
  assign a = in;
  assign b = in;
  assign aValid = inValid & toA;
  assign bValid = inValid & ~toA;

  // ready only from the side the word is heading to
  assign inReady = toA ? aReady : bReady;

endmodule

`default_nettype wire

//--- src/core.sv
`timescale 1ns/100ps
`default_nettype none

`include "hostLink_config.svh"

// small register file behind the host link
// also emits bias-driver words and captures incoming ones
module core (
  input  logic                  clk,
  input  logic                  reset,
  input  hostLinkPkg::hostWord  hostIn,
  input  logic                  hostInValid,
  output logic                  hostInReady,
  output hostLinkPkg::hostWord  hostOut,
  output logic                  hostOutValid,
  input  logic                  hostOutReady,
  input  hostLinkPkg::bdInWord  bdIn,
  input  logic                  bdInValid,
  output logic                  bdInReady,
  output hostLinkPkg::bdOutWord bdOut,
  output logic                  bdOutValid,
  input  logic                  bdOutReady
);

  localparam int regIdxW = $clog2(`NUM_REGS);
  // bias-driver address select bits, low bits carry through
  localparam int bdSelW = `BD_OUT_W - `REG_DATA_W;
  localparam logic [`REG_ADDR_W-1:0] numRegsAddr = `NUM_REGS;
  localparam logic [`REG_ADDR_W-1:0] bdBase = `BD_ADDR_BASE;
  // last two registers hold captured data and capture count
  localparam int capIdx = `NUM_REGS - 2;
  localparam int cntIdx = `NUM_REGS - 1;

  logic [`REG_DATA_W-1:0] regs [`NUM_REGS];

  hostLinkPkg::regCmd cmd;
  logic stall;
  logic accept;
  logic inRange;
  logic isBdAddr;
  logic regWrite;
  logic bdWrite;
  logic rdReq;
  logic capture;
  logic [regIdxW-1:0] idx;
  logic [`REG_DATA_W-1:0] rdData;

  ////////////////////////////////////////////////////////////
  // decode

  // payload read as address plus data
  assign cmd = hostIn.payload.cmd;
  assign idx = cmd.addr[regIdxW-1:0];
  assign inRange = cmd.addr < numRegsAddr;
  assign isBdAddr = cmd.addr[`REG_ADDR_W-1:bdSelW] == bdBase[`REG_ADDR_W-1:bdSelW];

  // an output still waiting blocks new commands
  assign stall = (hostOutValid & ~hostOutReady) | (bdOutValid & ~bdOutReady);
  assign hostInReady = ~stall;
  assign accept = hostInValid & hostInReady;

  assign regWrite = accept & (hostIn.code == `CODE_WRITE) & inRange;
  assign bdWrite = accept & (hostIn.code == `CODE_WRITE) & isBdAddr;
  assign rdReq = accept & (hostIn.code == `CODE_READ);

  // capture waits a cycle when the host writes the file
  assign bdInReady = ~regWrite;
  assign capture = bdInValid & bdInReady;

  // out of range reads return zero
  assign rdData = inRange ? regs[idx] : '0;

  ////////////////////////////////////////////////////////////
  // register file and valids

  always_ff @(posedge clk) begin
    if (reset) begin
      hostOutValid <= 1'b0;
      bdOutValid <= 1'b0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (hostOutReady) begin
        hostOutValid <= 1'b0;
      end
      if (bdOutReady) begin
        bdOutValid <= 1'b0;
      end
      if (rdReq) begin
        hostOutValid <= 1'b1;
      end
      if (bdWrite) begin
        bdOutValid <= 1'b1;
      end
      if (regWrite) begin
        regs[idx] <= cmd.data;
      end
      // low half of the bias-driver word plus a running count
      if (capture) begin
        regs[capIdx] <= bdIn[`REG_DATA_W-1:0];
        regs[cntIdx] <= regs[cntIdx] + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output words

  always_ff @(posedge clk) begin
    if (rdReq) begin
      hostOut.code <= `CODE_READ;
      hostOut.payload.cmd.addr <= cmd.addr;
      hostOut.payload.cmd.data <= rdData;
    end
    if (bdWrite) begin
      bdOut <= {cmd.addr[bdSelW-1:0], cmd.data};
    end
  end

endmodule

`default_nettype wire

//--- src/coreTestHarness.sv
`timescale 1ns/100ps
`default_nettype none

`include "hostLink_config.svh"

// core with its bias-driver ports looped out to the host link
// host injects bias-driver input and sees all bias-driver output
module coreTestHarness (
  input  logic                 clk,
  input  logic                 reset,
  input  hostLinkPkg::hostWord hostIn,
  input  logic                 hostInValid,
  output logic                 hostInReady,
  output hostLinkPkg::hostWord hostOut,
  output logic                 hostOutValid,
  input  logic                 hostOutReady
);

  localparam int padW = `HOST_DATA_W - `BD_OUT_W;

  // host side of the core
  hostLinkPkg::hostWord coreHostIn;
  logic coreHostInValid;
  logic coreHostInReady;
  hostLinkPkg::hostWord coreHostOut;
  logic coreHostOutValid;
  logic coreHostOutReady;

  // bias-driver side of the core
  hostLinkPkg::hostWord toBd;
  logic toBdValid;
  logic toBdReady;
  hostLinkPkg::bdInWord bdIn;
  logic bdInValid;
  logic bdInReady;
  hostLinkPkg::bdOutWord bdOut;
  logic bdOutValid;
  logic bdOutReady;
  hostLinkPkg::hostWord bdTagged;

  ////////////////////////////////////////////////////////////
  // host -> bias-driver input

  // all-ones code heads for the deserializer
  channelSplit #(
    .codeMatch(`CODE_TO_BD),
    .codeMask({`HOST_CODE_W{1'b1}})
  ) i_channelSplit (
    .in(hostIn),
    .inValid(hostInValid),
    .inReady(hostInReady),
    .a(toBd),
    .aValid(toBdValid),
    .aReady(toBdReady),
    .b(coreHostIn),
    .bValid(coreHostInValid),
    .bReady(coreHostInReady)
  );

  deserializer i_deserializer (
    .clk(clk),
    .reset(reset),
    .payload(toBd.payload.raw),
    .payloadValid(toBdValid),
    .payloadReady(toBdReady),
    .word(bdIn),
    .wordValid(bdInValid),
    .wordReady(bdInReady)
  );

  core i_core (
    .clk(clk),
    .reset(reset),
    .hostIn(coreHostIn),
    .hostInValid(coreHostInValid),
    .hostInReady(coreHostInReady),
    .hostOut(coreHostOut),
    .hostOutValid(coreHostOutValid),
    .hostOutReady(coreHostOutReady),
    .bdIn(bdIn),
    .bdInValid(bdInValid),
    .bdInReady(bdInReady),
    .bdOut(bdOut),
    .bdOutValid(bdOutValid),
    .bdOutReady(bdOutReady)
  );

  ////////////////////////////////////////////////////////////
  // bias-driver output -> host

  // tag with the all-ones code, zero pad up to the payload width
  assign bdTagged = {`CODE_FROM_BD, {padW{1'b0}}, bdOut};

  // core replies on a so they win the first tie
  channelMerge i_channelMerge (
    .clk(clk),
    .reset(reset),
    .a(coreHostOut),
    .aValid(coreHostOutValid),
    .aReady(coreHostOutReady),
    .b(bdTagged),
    .bValid(bdOutValid),
    .bReady(bdOutReady),
    .out(hostOut),
    .outValid(hostOutValid),
    .outReady(hostOutReady)
  );

endmodule

`default_nettype wire

//--- src/deserializer.sv
`timescale 1ns/100ps
`default_nettype none

`include "hostLink_config.svh"

// two host payload chunks make one bias-driver input word
module deserializer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`HOST_DATA_W-1:0] payload,
  input  logic                 payloadValid,
  output logic                 payloadReady,
  output hostLinkPkg::bdInWord word,
  output logic                 wordValid,
  input  logic                 wordReady
);

  // bits left for the second chunk
  localparam int hiW = `BD_IN_W - `HOST_DATA_W;

  // low when the next chunk is the first of a pair
  logic phase;
  logic take;

  // holding register busy until the core takes it
  assign payloadReady = ~wordValid;
  assign take = payloadValid & payloadReady;

  ////////////////////////////////////////////////////////////
  // phase and valid

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= 1'b0;
      wordValid <= 1'b0;
    end else begin
      if (wordValid && wordReady) begin
        wordValid <= 1'b0;
      end
      if (take) begin
        phase <= ~phase;
        // second chunk completes the word
        if (phase) begin
          wordValid <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // assembly

  always_ff @(posedge clk) begin
    if (take) begin
      if (!phase) begin
        word[`HOST_DATA_W-1:0] <= payload;
      end else begin
        // upper chunk bits beyond the word are dropped
        word[`BD_IN_W-1:`HOST_DATA_W] <= payload[hiW-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/hostLinkPkg.sv
`default_nettype none

`include "hostLink_config.svh"

package hostLinkPkg;

  // register command as the core sees the payload
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] addr;
    logic [`REG_DATA_W-1:0] data;
  } regCmd;

  // same 24 bits, either a register command or raw deserializer chunk
  typedef union packed {
    regCmd cmd;
    logic [`HOST_DATA_W-1:0] raw;
  } hostPayload;

  // full host link word, code in the top bits
  typedef struct packed {
    logic [`HOST_CODE_W-1:0] code;
    hostPayload payload;
  } hostWord;

  // word into the core from the bias-driver side
  typedef logic [`BD_IN_W-1:0] bdInWord;

  // word from the core toward the bias driver
  typedef logic [`BD_OUT_W-1:0] bdOutWord;

endpackage

`default_nettype wire

//--- test/coreTestHarnessTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "hostLink_config.svh"

module coreTestHarnessTb;

  localparam int timeoutCycles = 1000;
  localparam int burstLen = 32;

  logic clk;
  logic reset;
  hostLinkPkg::hostWord hostIn;
  logic hostInValid;
  logic hostInReady;
  hostLinkPkg::hostWord hostOut;
  logic hostOutValid;
  logic hostOutReady;

  logic [31:0] lfsr;
  // register file contents expected after each write or capture
  logic [`REG_DATA_W-1:0] regModel [`NUM_REGS];
  // expected words for each source kept in separate queues
  hostLinkPkg::hostWord readQ[$];
  hostLinkPkg::hostWord bdQ[$];
  hostLinkPkg::hostWord burstWords[$];
  int stallLens [burstLen];

  coreTestHarness i_coreTestHarness (
    .clk(clk),
    .reset(reset),
    .hostIn(hostIn),
    .hostInValid(hostInValid),
    .hostInReady(hostInReady),
    .hostOut(hostOut),
    .hostOutValid(hostOutValid),
    .hostOutReady(hostOutReady)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic hostLinkPkg::hostWord makeCmd(input logic [7:0] code,
                                                   input logic [7:0] addr,
                                                   input logic [15:0] data);
    hostLinkPkg::hostWord w;
    w.code = code;
    w.payload.cmd.addr = addr;
    w.payload.cmd.data = data;
    return w;
  endfunction

  // bias-driver output as the host sees it with tag, three zero bits, select and data
  function automatic hostLinkPkg::hostWord makeBdOut(input logic [4:0] sel,
                                                     input logic [15:0] data);
    hostLinkPkg::hostWord w;
    w.code = `CODE_FROM_BD;
    w.payload.raw = {3'b000, sel, data};
    return w;
  endfunction

  task automatic stopOnError(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // called and returns on a falling edge
  task automatic sendWord(input hostLinkPkg::hostWord w);
    int waited;
    waited = 0;
    hostIn = w;
    hostInValid = 1'b1;
    @(posedge clk);
    while (!hostInReady) begin
      waited++;
      if (waited > timeoutCycles) begin
        stopOnError("timeout: the harness never accepted a host word");
      end
      @(posedge clk);
    end
    @(negedge clk);
    hostInValid = 1'b0;
  endtask

  task automatic receiveWord(output hostLinkPkg::hostWord w);
    int waited;
    waited = 0;
    hostOutReady = 1'b1;
    @(posedge clk);
    while (!hostOutValid) begin
      waited++;
      if (waited > timeoutCycles) begin
        stopOnError("timeout: no word came out on the host output");
      end
      @(posedge clk);
    end
    w = hostOut;
    @(negedge clk);
    hostOutReady = 1'b0;
  endtask

  task automatic expectWord(input hostLinkPkg::hostWord exp);
    hostLinkPkg::hostWord got;
    receiveWord(got);
    check("hostOut", got, exp);
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [15:0] data);
    sendWord(makeCmd(`CODE_WRITE, addr, data));
    if (addr < `NUM_REGS) begin
      regModel[addr[3:0]] = data;
    end
  endtask

  // unmapped addresses read back as zero
  task automatic readReg(input logic [7:0] addr);
    logic [15:0] exp;
    exp = (addr < `NUM_REGS) ? regModel[addr[3:0]] : 16'h0000;
    sendWord(makeCmd(`CODE_READ, addr, 16'h0000));
    expectWord(makeCmd(`CODE_READ, addr, exp));
  endtask

  // register 14 takes the low half of the first chunk and 15 counts words
  task automatic sendBdPair(input logic [23:0] p0, input logic [23:0] p1);
    hostLinkPkg::hostWord w;
    w.code = `CODE_TO_BD;
    w.payload.raw = p0;
    sendWord(w);
    w.payload.raw = p1;
    sendWord(w);
    regModel[14] = p0[15:0];
    regModel[15] = regModel[15] + 16'd1;
    // one cycle in the deserializer and one more until the capture is readable
    idleCycles(2);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic registerRoundTrip;
    logic [15:0] d;
    for (int r = 0; r < 14; r++) begin
      d = 16'(randBits(16));
      writeReg(8'(r), d);
      readReg(8'(r));
    end
  endtask

  task automatic unknownCodeAndRange;
    hostLinkPkg::hostWord w;
    readReg(8'h10);
    readReg(8'h7F);
    // unknown code is dropped so the next output is the read reply
    w.code = 8'h55;
    w.payload.raw = 24'(randBits(24));
    sendWord(w);
    readReg(8'h03);
  endtask

  task automatic bdOutputEcho;
    logic [15:0] d;
    logic [4:0] sel [3];
    sel = '{5'd0, 5'd7, 5'd31};
    foreach (sel[i]) begin
      d = 16'(randBits(16));
      sendWord(makeCmd(`CODE_WRITE, `BD_ADDR_BASE + 8'(sel[i]), d));
      expectWord(makeBdOut(sel[i], d));
    end
  endtask

  task automatic bdInputCapture;
    sendBdPair(24'(randBits(24)), 24'(randBits(24)));
    readReg(8'd14);
    readReg(8'd15);
    for (int n = 0; n < 3; n++) begin
      sendBdPair(24'(randBits(24)), 24'(randBits(24)));
    end
    readReg(8'd15);
    readReg(8'd14);
  endtask

  task automatic sendBurst;
    foreach (burstWords[i]) begin
      sendWord(burstWords[i]);
    end
  endtask

  task automatic receiveBurst;
    hostLinkPkg::hostWord w;
    hostLinkPkg::hostWord exp;
    for (int i = 0; i < burstLen; i++) begin
      hostOutReady = 1'b0;
      idleCycles(stallLens[i]);
      receiveWord(w);
      if (w.code == `CODE_READ) begin
        if (readQ.size() == 0) begin
          stopOnError("a read reply came out with none outstanding");
        end
        exp = readQ.pop_front();
      end else if (w.code == `CODE_FROM_BD) begin
        if (bdQ.size() == 0) begin
          stopOnError("a bias-driver word came out with none outstanding");
        end
        exp = bdQ.pop_front();
      end else begin
        stopOnError("a word with an unexpected code came out");
      end
      check("hostOut", w, exp);
    end
  endtask

  // mixed reads and bias-driver writes under random output stalls
  task automatic backPressureBurst;
    logic [3:0] r;
    logic [15:0] d;
    // all stimulus drawn up front so the order is fixed
    for (int i = 0; i < burstLen; i++) begin
      if (randBits(1) == 1) begin
        r = 4'(randBits(4));
        burstWords.push_back(makeCmd(`CODE_READ, 8'(r), 16'h0000));
        readQ.push_back(makeCmd(`CODE_READ, 8'(r), regModel[r]));
      end else begin
        d = 16'(randBits(16));
        burstWords.push_back(makeCmd(`CODE_WRITE, `BD_ADDR_BASE + 8'(i % 32), d));
        bdQ.push_back(makeBdOut(5'(i % 32), d));
      end
      stallLens[i] = int'(randBits(3));
    end
    fork
      sendBurst();
      receiveBurst();
    join
    // nothing extra may follow
    hostOutReady = 1'b1;
    repeat (8) begin
      @(posedge clk);
      check("hostOutValid", 32'(hostOutValid), 32'd0);
    end
    @(negedge clk);
    hostOutReady = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    hostIn = '0;
    hostInValid = 1'b0;
    hostOutReady = 1'b0;
    lfsr = 32'h456da3ae;
    for (int i = 0; i < `NUM_REGS; i++) begin
      regModel[i] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    registerRoundTrip();
    unknownCodeAndRange();
    bdOutputEcho();
    bdInputCapture();
    backPressureBurst();

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
